//--- branch_cluster.f
+incdir+common
common/isa_pkg.sv
common/station_pkg.sv
common/station_unit_if.sv
common/result_bus_if.sv
station/issue_control.sv
station/branch_station.sv
logic/branch.sv
logic/branch_result.sv
logic/branch_cluster.sv
testbench/branch_cluster_chk.sv
testbench/branch_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module branch_cluster_tb \
    -f branch_cluster.f \
    -o sim_branch_cluster

./obj_dir/sim_branch_cluster > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1

//--- testbench/branch_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cluster_tb;

    localparam int NUM_OPS = 44;

    typedef struct packed {
        logic [31:0] target;
        logic [31:0] link;
        logic        write;
        logic        taken;
    } expect_t;

    logic clk;
    logic rst_n;
    logic flush;
    logic dispatch_valid;
    isa_pkg::instr_name_t dispatch_instr;
    station_pkg::tag_t dispatch_tag;
    isa_pkg::xlen_t dispatch_address;
    isa_pkg::imm_t dispatch_immediate;
    logic src1_ready;
    isa_pkg::xlen_t src1_value;
    station_pkg::tag_t src1_tag;
    logic src2_ready;
    isa_pkg::xlen_t src2_value;
    station_pkg::tag_t src2_tag;
    logic cdb_valid;
    station_pkg::tag_t cdb_tag;
    isa_pkg::xlen_t cdb_value;
    logic cdb_write;
    logic full;
    logic result_valid;
    station_pkg::tag_t result_tag;
    isa_pkg::xlen_t result_value;
    logic result_write;
    logic jump_taken;
    isa_pkg::xlen_t jump_target;

    // Scoreboard and operations still waiting for operands, indexed by tag
    expect_t expected [16];
    logic pending [16];
    logic held [16];
    isa_pkg::instr_name_t held_op [16];
    logic [31:0] held_pc [16];
    logic [31:0] held_imm [16];
    logic [31:0] held_v1 [16];
    logic [31:0] held_v2 [16];
    logic need1 [16];
    logic need2 [16];
    logic [3:0] wait1 [16];
    logic [3:0] wait2 [16];

    int errors = 0;
    int outstanding = 0;
    logic [31:0] lfsr_state = 32'hcd48;

    branch_cluster UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((NUM_OPS + 40) * 8 * 100);
        $display("Timeout: results did not arrive in time");
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_imm();
        logic [31:0] b;
        b = take_bits(12);
        return {{19{b[11]}}, b[11:0], 1'b0};
    endfunction

    function automatic expect_t branch_ref(input isa_pkg::instr_name_t op,
                                           input logic [31:0] pc, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] imm);
        expect_t e;
        logic cond;
        logic is_cond;
        e = '0;
        cond = 1'b0;
        is_cond = 1'b1;
        case (op)
            isa_pkg::JAL: begin
                e = '{pc + imm, pc + 32'd4, 1'b1, 1'b1};
                is_cond = 1'b0;
            end
            isa_pkg::JALR: begin
                e = '{a + imm, pc + 32'd4, 1'b1, 1'b1};
                is_cond = 1'b0;
            end
            isa_pkg::BEQ:  cond = (a == b);
            isa_pkg::BNE:  cond = (a != b);
            isa_pkg::BLT:  cond = ($signed(a) < $signed(b));
            isa_pkg::BGE:  cond = ($signed(a) >= $signed(b));
            isa_pkg::BLTU: cond = (a < b);
            isa_pkg::BGEU: cond = (a >= b);
            default:       is_cond = 1'b0;
        endcase
        if (is_cond) begin
            e.target = cond ? pc + imm : pc + 32'd4;
            e.taken = cond;
        end
        return e;
    endfunction

    // Operands known, so the result can be predicted
    function automatic void arm(input int t);
        expected[t] = branch_ref(held_op[t], held_pc[t], held_v1[t], held_v2[t], held_imm[t]);
        pending[t] = 1'b1;
        held[t] = 1'b0;
        outstanding++;
    endfunction

    // Link values of newly armed jumps wake further operations in turn
    function automatic void resolve(input logic [3:0] tag, input logic [31:0] value);
        logic [3:0] tags [$];
        logic [31:0] values [$];
        logic [3:0] cur_tag;
        logic [31:0] cur_value;
        tags.push_back(tag);
        values.push_back(value);
        while (tags.size() > 0) begin
            cur_tag = tags.pop_front();
            cur_value = values.pop_front();
            for (int t = 0; t < 16; t++) begin
                if (held[t]) begin
                    if (need1[t] && wait1[t] == cur_tag) begin
                        held_v1[t] = cur_value;
                        need1[t] = 1'b0;
                    end
                    if (need2[t] && wait2[t] == cur_tag) begin
                        held_v2[t] = cur_value;
                        need2[t] = 1'b0;
                    end
                    if (!need1[t] && !need2[t]) begin
                        arm(t);
                        if (expected[t].write) begin
                            tags.push_back(4'(t));
                            values.push_back(expected[t].link);
                        end
                    end
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // All stimulus tasks start and end 10 ns after a rising edge
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic dispatch_op(input isa_pkg::instr_name_t op, input logic [3:0] tag,
                               input logic [31:0] pc, input logic [31:0] imm,
                               input logic r1, input logic [31:0] v1, input logic [3:0] t1,
                               input logic r2, input logic [31:0] v2, input logic [3:0] t2);
        held[tag] = 1'b1;
        held_op[tag] = op;
        held_pc[tag] = pc;
        held_imm[tag] = imm;
        held_v1[tag] = v1;
        held_v2[tag] = v2;
        need1[tag] = !r1;
        need2[tag] = !r2;
        wait1[tag] = t1;
        wait2[tag] = t2;
        dispatch_valid = 1'b1;
        dispatch_instr = op;
        dispatch_tag = tag;
        dispatch_address = pc;
        dispatch_immediate = imm;
        src1_ready = r1;
        src1_value = v1;
        src1_tag = t1;
        src2_ready = r2;
        src2_value = v2;
        src2_tag = t2;
        if (r1 && r2) begin
            arm(int'(tag));
            if (expected[tag].write) begin
                resolve(tag, expected[tag].link);
            end
        end
        @(posedge clk);
        #10;
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [3:0] tag, input logic [31:0] value);
        cdb_valid = 1'b1;
        cdb_tag = tag;
        cdb_value = value;
        cdb_write = 1'b1;
        resolve(tag, value);
        @(posedge clk);
        #10;
        cdb_valid = 1'b0;
    endtask

    task automatic drain();
        wait (outstanding == 0);
        repeat (3) @(posedge clk);
        #10;
    endtask

    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (!pending[result_tag]) begin
                errors++;
                $display("Error: result for tag %0d was not expected", result_tag);
            end else begin
                check_value("result_value", result_value, expected[result_tag].link);
                check_value("result_write", 32'(result_write), 32'(expected[result_tag].write));
                check_value("jump_taken", 32'(jump_taken), 32'(expected[result_tag].taken));
                check_value("jump_target", jump_target, expected[result_tag].target);
                pending[result_tag] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        isa_pkg::instr_name_t conds [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0] tag;
        conds = '{isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
                  isa_pkg::BGE, isa_pkg::BLTU, isa_pkg::BGEU};
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
            held[t] = 1'b0;
        end
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_instr = isa_pkg::NOP;
        dispatch_tag = '0;
        dispatch_address = '0;
        dispatch_immediate = '0;
        src1_ready = 1'b0;
        src1_value = '0;
        src1_tag = '0;
        src2_ready = 1'b0;
        src2_value = '0;
        src2_tag = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        cdb_write = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Quiet outputs after reset
        check_value("result_valid", 32'(result_valid), 32'd0);
        check_value("result_write", 32'(result_write), 32'd0);
        check_value("full", 32'(full), 32'd0);

        // Lone jumps arrive two edges after dispatch
        dispatch_op(isa_pkg::JAL, 4'd0, take_bits(30) << 2, rand_imm(),
                    1'b1, 32'd0, 4'd0, 1'b1, 32'd0, 4'd0);
        idle(1);
        check_value("result_valid", 32'(result_valid), 32'd0);
        idle(1);
        check_value("result_valid", 32'(result_valid), 32'd1);
        check_value("result_tag", 32'(result_tag), 32'd0);
        dispatch_op(isa_pkg::JALR, 4'd1, take_bits(30) << 2, rand_imm(),
                    1'b1, take_bits(32), 4'd0, 1'b1, 32'd0, 4'd0);
        idle(1);
        check_value("result_valid", 32'(result_valid), 32'd0);
        idle(1);
        check_value("result_valid", 32'(result_valid), 32'd1);
        check_value("result_tag", 32'(result_tag), 32'd1);
        drain();

        // Conditional branches with random, equal and edge pairs
        tag = 4'd2;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                a = take_bits(32);
                b = take_bits(32);
                case (p)
                    1: b = a;
                    2: begin
                        a = 32'h80000000;
                        b = 32'h7fffffff;
                    end
                    3: begin
                        a = 32'hffffffff;
                        b = 32'h00000001;
                    end
                    4: begin
                        a = 32'h00000000;
                        b = 32'hffffffff;
                    end
                    default: ;
                endcase
                dispatch_op(conds[c], tag, take_bits(30) << 2, rand_imm(),
                            1'b1, a, 4'd0, 1'b1, b, 4'd0);
                tag = tag + 4'd1;
            end
        end
        drain();

        // Wakeup from the common data bus and from the own link result
        dispatch_op(isa_pkg::BEQ, 4'd0, take_bits(30) << 2, rand_imm(),
                    1'b0, 32'd0, 4'd10, 1'b1, take_bits(32), 4'd0);
        dispatch_op(isa_pkg::JALR, 4'd1, take_bits(30) << 2, rand_imm(),
                    1'b0, 32'd0, 4'd2, 1'b1, 32'd0, 4'd0);
        idle(3);
        dispatch_op(isa_pkg::JAL, 4'd2, take_bits(30) << 2, rand_imm(),
                    1'b1, 32'd0, 4'd0, 1'b1, 32'd0, 4'd0);
        broadcast(4'd10, take_bits(32));
        drain();

        // Fill the station, then wake in reverse order
        for (int i = 0; i < 4; i++) begin
            dispatch_op(isa_pkg::BLTU, 4'(4 + i), take_bits(30) << 2, rand_imm(),
                        1'b0, 32'd0, 4'(12 + i), 1'b1, take_bits(32), 4'd0);
        end
        check_value("full", 32'(full), 32'd1);
        for (int i = 3; i >= 0; i--) begin
            broadcast(4'(12 + i), take_bits(32));
        end
        drain();
        check_value("full", 32'(full), 32'd0);

        // Flush waiting entries
        for (int i = 3; i < 6; i++) begin
            dispatch_op(isa_pkg::BGE, 4'(i), take_bits(30) << 2, rand_imm(),
                        1'b0, 32'd0, 4'd11, 1'b1, take_bits(32), 4'd0);
        end
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
        for (int i = 3; i < 6; i++) begin
            held[i] = 1'b0;
        end
        check_value("full", 32'(full), 32'd0);
        broadcast(4'd11, take_bits(32));
        idle(4);
        dispatch_op(isa_pkg::BNE, 4'd6, take_bits(30) << 2, rand_imm(),
                    1'b1, take_bits(32), 4'd0, 1'b1, take_bits(32), 4'd0);
        dispatch_op(isa_pkg::JAL, 4'd7, take_bits(30) << 2, rand_imm(),
                    1'b1, 32'd0, 4'd0, 1'b1, 32'd0, 4'd0);
        drain();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/branch_cluster_chk.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cluster_chk (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic dispatch_valid,
    input logic full,
    input logic result_valid,
    input logic result_write,
    input logic jump_taken
);

    // Dispatcher must respect back-pressure
    no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(dispatch_valid && full))
        else $error("dispatch while full");

    no_result_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !result_valid)
        else $error("result in the cycle after flush");

    // Link results only come from jumps, which are always taken
    write_implies_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && result_write) |-> jump_taken)
        else $error("result_write without jump_taken");

    full_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !full)
        else $error("full high after reset");

endmodule

bind branch_cluster branch_cluster_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .full           (full),
    .result_valid   (result_valid),
    .result_write   (result_write),
    .jump_taken     (jump_taken)
);

`default_nettype wire

//--- logic/branch_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cluster (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    dispatch_valid,
    input  isa_pkg::instr_name_t    dispatch_instr,
    input  station_pkg::tag_t       dispatch_tag,
    input  isa_pkg::xlen_t          dispatch_address,
    input  isa_pkg::imm_t           dispatch_immediate,
    input  logic                    src1_ready,
    input  isa_pkg::xlen_t          src1_value,
    input  station_pkg::tag_t       src1_tag,
    input  logic                    src2_ready,
    input  isa_pkg::xlen_t          src2_value,
    input  station_pkg::tag_t       src2_tag,
    input  logic                    cdb_valid,
    input  station_pkg::tag_t       cdb_tag,
    input  isa_pkg::xlen_t          cdb_value,
    input  logic                    cdb_write,
    output logic                    full,
    output logic                    result_valid,
    output station_pkg::tag_t       result_tag,
    output isa_pkg::xlen_t          result_value,
    output logic                    result_write,
    output logic                    jump_taken,
    output isa_pkg::xlen_t          jump_target
);

    result_bus_if   cdb ();
    result_bus_if   own ();
    station_unit_if exec_feed ();

    station_pkg::entry_mask_t busy;
    station_pkg::entry_mask_t ready;
    station_pkg::index_t alloc_index;
    station_pkg::index_t issue_index;
    logic alloc_write;
    logic issue_fire;
    logic clear;
    isa_pkg::xlen_t store_result;
    isa_pkg::xlen_t jump_result;
    logic taken;

    assign cdb.valid = cdb_valid;
    assign cdb.tag   = cdb_tag;
    assign cdb.value = cdb_value;
    assign cdb.write = cdb_write;

    assign result_valid = own.valid;
    assign result_tag   = own.tag;
    assign result_value = own.value;
    assign result_write = own.write;

    issue_control u_issue_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .ready          (ready),
        .busy           (busy),
        .alloc_index    (alloc_index),
        .alloc_write    (alloc_write),
        .issue_fire     (issue_fire),
        .issue_index    (issue_index),
        .full           (full),
        .clear          (clear)
    );

    branch_station u_branch_station (
        .clk                (clk),
        .rst_n              (rst_n),
        .dispatch_instr     (dispatch_instr),
        .dispatch_tag       (dispatch_tag),
        .dispatch_address   (dispatch_address),
        .dispatch_immediate (dispatch_immediate),
        .src1_ready         (src1_ready),
        .src1_value         (src1_value),
        .src1_tag           (src1_tag),
        .src2_ready         (src2_ready),
        .src2_value         (src2_value),
        .src2_tag           (src2_tag),
        .alloc_write        (alloc_write),
        .alloc_index        (alloc_index),
        .busy               (busy),
        .issue_fire         (issue_fire),
        .issue_index        (issue_index),
        .clear              (clear),
        .cdb                (cdb.sink),
        .own                (own.sink),
        .ready              (ready),
        .exec_feed          (exec_feed.station)
    );

    branch u_branch (
        .exec_feed    (exec_feed.unit),
        .store_result (store_result),
        .jump_result  (jump_result),
        .taken        (taken)
    );

    branch_result u_branch_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .exec_feed    (exec_feed.unit),
        .store_result (store_result),
        .jump_result  (jump_result),
        .taken        (taken),
        .own          (own.source),
        .jump_taken   (jump_taken),
        .jump_target  (jump_target)
    );

endmodule

`default_nettype wire

//--- logic/branch_result.sv
`timescale 1ns/100ps
`default_nettype none

module branch_result (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear,
    station_unit_if.unit    exec_feed,
    input  isa_pkg::xlen_t  store_result,
    input  isa_pkg::xlen_t  jump_result,
    input  logic            taken,
    result_bus_if.source    own,
    output logic            jump_taken,
    output isa_pkg::xlen_t  jump_target
);

    logic is_link;

    assign is_link = (exec_feed.instr_name == isa_pkg::JAL) ||
                     (exec_feed.instr_name == isa_pkg::JALR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own.valid <= 1'b0;
            own.write <= 1'b0;
        end else begin
            own.valid <= exec_feed.valid && !clear;
            own.write <= exec_feed.valid && !clear && is_link;
        end
    end

    // Payload only follows a valid operation
    always_ff @(posedge clk) begin
        if (exec_feed.valid) begin
            own.tag     <= exec_feed.tag;
            own.value   <= store_result;
            jump_taken  <= taken;
            jump_target <= jump_result;
        end
    end

endmodule

`default_nettype wire

//--- logic/branch.sv
`timescale 1ns/100ps
`default_nettype none

module branch (
    station_unit_if.unit    exec_feed,
    output isa_pkg::xlen_t  store_result,
    output isa_pkg::xlen_t  jump_result,
    output logic            taken
);

    isa_pkg::xlen_t next_pc;
    isa_pkg::xlen_t offset_pc;
    logic equal;
    logic less_signed;
    logic less_unsigned;
    logic cond;

    assign next_pc       = exec_feed.address + isa_pkg::xlen_t'(4);
    assign offset_pc     = exec_feed.address + exec_feed.immediate;
    assign equal         = exec_feed.data_1 == exec_feed.data_2;
    assign less_signed   = $signed(exec_feed.data_1) < $signed(exec_feed.data_2);
    assign less_unsigned = exec_feed.data_1 < exec_feed.data_2;

    always_comb begin
        case (exec_feed.instr_name)
            isa_pkg::BEQ:  cond = equal;
            isa_pkg::BNE:  cond = !equal;
            isa_pkg::BLT:  cond = less_signed;
            isa_pkg::BGE:  cond = !less_signed;
            isa_pkg::BLTU: cond = less_unsigned;
            isa_pkg::BGEU: cond = !less_unsigned;
            default:       cond = 1'b0;
        endcase
    end

    always_comb begin
        store_result = '0;
        jump_result  = '0;
        taken        = 1'b0;
        case (exec_feed.instr_name)
            isa_pkg::JAL: begin
                jump_result  = offset_pc;
                store_result = next_pc;
                taken        = 1'b1;
            end
            isa_pkg::JALR: begin
                // Register-relative target
                jump_result  = exec_feed.data_1 + exec_feed.immediate;
                store_result = next_pc;
                taken        = 1'b1;
            end
            isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
            isa_pkg::BGE, isa_pkg::BLTU, isa_pkg::BGEU: begin
                jump_result = cond ? offset_pc : next_pc;
                taken       = cond;
            end
            default: begin
                // NOP leaves everything at zero
                taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- station/branch_station.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_cluster_defines.svh"

module branch_station (
    input  logic                        clk,
    input  logic                        rst_n,
    input  isa_pkg::instr_name_t        dispatch_instr,
    input  station_pkg::tag_t           dispatch_tag,
    input  isa_pkg::xlen_t              dispatch_address,
    input  isa_pkg::imm_t               dispatch_immediate,
    input  logic                        src1_ready,
    input  isa_pkg::xlen_t              src1_value,
    input  station_pkg::tag_t           src1_tag,
    input  logic                        src2_ready,
    input  isa_pkg::xlen_t              src2_value,
    input  station_pkg::tag_t           src2_tag,
    input  logic                        alloc_write,
    input  station_pkg::index_t         alloc_index,
    input  station_pkg::entry_mask_t    busy,
    input  logic                        issue_fire,
    input  station_pkg::index_t         issue_index,
    input  logic                        clear,
    result_bus_if.sink                  cdb,
    result_bus_if.sink                  own,
    output station_pkg::entry_mask_t    ready,
    station_unit_if.station             exec_feed
);

    isa_pkg::instr_name_t   instr_q   [`STATION_DEPTH];
    station_pkg::tag_t      tag_q     [`STATION_DEPTH];
    isa_pkg::xlen_t         address_q [`STATION_DEPTH];
    isa_pkg::imm_t          imm_q     [`STATION_DEPTH];
    isa_pkg::xlen_t         val1_q    [`STATION_DEPTH];
    isa_pkg::xlen_t         val2_q    [`STATION_DEPTH];
    station_pkg::tag_t      wait1_q   [`STATION_DEPTH];
    station_pkg::tag_t      wait2_q   [`STATION_DEPTH];
    station_pkg::entry_mask_t rdy1_q;
    station_pkg::entry_mask_t rdy2_q;

    // A register result on either bus for this tag
    function automatic logic snoop_hit(input station_pkg::tag_t t);
        return (cdb.valid && cdb.write && cdb.tag == t) ||
               (own.valid && own.write && own.tag == t);
    endfunction

    function automatic isa_pkg::xlen_t snoop_value(input station_pkg::tag_t t);
        return (cdb.valid && cdb.write && cdb.tag == t) ? cdb.value : own.value;
    endfunction

    assign ready = rdy1_q & rdy2_q;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `STATION_DEPTH; i++) begin
            if (alloc_write && alloc_index == station_pkg::index_t'(i)) begin
                instr_q[i]   <= dispatch_instr;
                tag_q[i]     <= dispatch_tag;
                address_q[i] <= dispatch_address;
                imm_q[i]     <= dispatch_immediate;
                wait1_q[i]   <= src1_tag;
                wait2_q[i]   <= src2_tag;
                // Same-cycle broadcast is taken in as well
                rdy1_q[i]    <= src1_ready || snoop_hit(src1_tag);
                rdy2_q[i]    <= src2_ready || snoop_hit(src2_tag);
                val1_q[i]    <= src1_ready ? src1_value : snoop_value(src1_tag);
                val2_q[i]    <= src2_ready ? src2_value : snoop_value(src2_tag);
            end else if (busy[i]) begin
                if (!rdy1_q[i] && snoop_hit(wait1_q[i])) begin
                    rdy1_q[i] <= 1'b1;
                    val1_q[i] <= snoop_value(wait1_q[i]);
                end
                if (!rdy2_q[i] && snoop_hit(wait2_q[i])) begin
                    rdy2_q[i] <= 1'b1;
                    val2_q[i] <= snoop_value(wait2_q[i]);
                end
            end
        end
    end

    // Issue read-out, loaded on the edge that frees the entry
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            exec_feed.instr_name <= instr_q[issue_index];
            exec_feed.address    <= address_q[issue_index];
            exec_feed.data_1     <= val1_q[issue_index];
            exec_feed.data_2     <= val2_q[issue_index];
            exec_feed.immediate  <= imm_q[issue_index];
            exec_feed.tag        <= tag_q[issue_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_feed.valid <= 1'b0;
        end else begin
            exec_feed.valid <= issue_fire && !clear;
        end
    end

endmodule

`default_nettype wire

//--- station/issue_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_cluster_defines.svh"

module issue_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        dispatch_valid,
    input  station_pkg::entry_mask_t    ready,
    output station_pkg::entry_mask_t    busy,
    output station_pkg::index_t         alloc_index,
    output logic                        alloc_write,
    output logic                        issue_fire,
    output station_pkg::index_t         issue_index,
    output logic                        full,
    output logic                        clear
);

    station_pkg::issue_state_t state;
    station_pkg::entry_mask_t candidates;
    logic running;

    assign running    = (state == station_pkg::RUN) && !flush;
    assign candidates = busy & ready;
    assign full       = &busy;

    assign alloc_write = dispatch_valid && !full && running;
    assign issue_fire  = running && |candidates;
    // Flush cycle and the FLUSH state both kill work in flight
    assign clear       = flush || (state == station_pkg::FLUSH);

    // Lowest free entry and lowest ready entry
    always_comb begin
        alloc_index = '0;
        issue_index = '0;
        for (int i = `STATION_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_index = station_pkg::index_t'(i);
            end
            if (candidates[i]) begin
                issue_index = station_pkg::index_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= station_pkg::RUN;
        end else begin
            // FLUSH lasts one cycle past the last flush strobe
            state <= flush ? station_pkg::FLUSH : station_pkg::RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= '0;
        end else begin
            if (issue_fire) begin
                busy[issue_index] <= 1'b0;
            end
            if (alloc_write) begin
                busy[alloc_index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/result_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// Tagged result broadcast
interface result_bus_if;

    logic valid;
    station_pkg::tag_t tag;
    isa_pkg::xlen_t value;
    // Value is a register result
    logic write;

    modport source (
        output valid,
        output tag,
        output value,
        output write
    );

    modport sink (
        input valid,
        input tag,
        input value,
        input write
    );

endinterface

`default_nettype wire

//--- common/station_unit_if.sv
`timescale 1ns/100ps
`default_nettype none

// One issued operation on its way to an execution unit
interface station_unit_if;

    logic valid;
    isa_pkg::instr_name_t instr_name;
    isa_pkg::xlen_t address;
    isa_pkg::xlen_t data_1;
    isa_pkg::xlen_t data_2;
    isa_pkg::imm_t immediate;
    station_pkg::tag_t tag;

    modport station (
        output valid,
        output instr_name,
        output address,
        output data_1,
        output data_2,
        output immediate,
        output tag
    );

    modport unit (
        input valid,
        input instr_name,
        input address,
        input data_1,
        input data_2,
        input immediate,
        input tag
    );

endinterface

`default_nettype wire

//--- common/station_pkg.sv
`default_nettype none

`include "branch_cluster_defines.svh"

package station_pkg;

    // Producer tag
    typedef logic [`TAG_W-1:0] tag_t;

    // Entry number inside the station
    typedef logic [`INDEX_W-1:0] index_t;

    // One bit per station entry
    typedef logic [`STATION_DEPTH-1:0] entry_mask_t;

    // Issue control FSM
    typedef enum logic {
        RUN,
        FLUSH
    } issue_state_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

`include "branch_cluster_defines.svh"

package isa_pkg;

    // Control transfer operations handled by the cluster
    typedef enum logic [`INSTR_W-1:0] {
        NOP,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } instr_name_t;

    // Operand, address and result word
    typedef logic [`XLEN-1:0] xlen_t;

    // Sign-extended immediate, kept apart from operand data
    typedef logic [`XLEN-1:0] imm_t;

endpackage

`default_nettype wire

//--- common/branch_cluster_defines.svh
`ifndef BRANCH_CLUSTER_DEFINES_SVH
`define BRANCH_CLUSTER_DEFINES_SVH

// Data and address width
`define XLEN 32

// Width of the instruction name encoding
`define INSTR_W 4

// Station geometry
`define STATION_DEPTH 4
`define INDEX_W 2

// Producer tag from the reorder buffer
`define TAG_W 4

`endif
